// File: rtl/nodePkg.sv
package nodePkg;

	// activation and weight width.
	localparam int ActWidth = 8;

	// one sign-extended product.
	localparam int ProdWidth = 16;

	// accumulator, wide enough for every product plus the bias.
	localparam int AccWidth = 23;

	// geometry of the reference neuron.
	localparam int DefaultInputs = 75;
	localparam int DefaultGroupSize = 25;

	// trained weights, input order.
	localparam logic signed [ActWidth-1:0] NodeWeights [DefaultInputs] = '{
		-8'sd2,  -8'sd26, -8'sd26, 8'sd2,   8'sd12,
		8'sd4,   8'sd34,  8'sd24,  8'sd14,  8'sd10,
		-8'sd24, -8'sd22, -8'sd54, -8'sd40, -8'sd2,
		8'sd50,  8'sd36,  8'sd30,  8'sd26,  8'sd20,
		8'sd22,  -8'sd2,  -8'sd20, 8'sd18,  8'sd22,
		-8'sd12, -8'sd4,  -8'sd12, 8'sd4,   8'sd2,
		-8'sd18, 8'sd0,   8'sd8,   8'sd16,  -8'sd10,
		8'sd4,   8'sd6,   8'sd4,   8'sd4,   8'sd0,
		-8'sd2,  -8'sd2,  -8'sd6,  8'sd20,  8'sd12,
		8'sd10,  -8'sd4,  8'sd12,  8'sd2,   8'sd6,
		-8'sd2,  8'sd2,   -8'sd2,  8'sd14,  8'sd30,
		8'sd20,  -8'sd4,  -8'sd12, -8'sd2,  8'sd30,
		8'sd12,  8'sd6,   -8'sd20, 8'sd26,  -8'sd12,
		-8'sd26, -8'sd26, -8'sd22, -8'sd24, 8'sd2,
		-8'sd4,  8'sd6,   -8'sd4,  -8'sd8,  8'sd16
	};

	// bias, already in accumulator format.
	localparam logic signed [AccWidth-1:0] NodeBias = 23'sd512;

	// quantizer.
	// the output keeps bits FracBits+ActWidth-1 down to FracBits.
	localparam int FracBits = 6;

	// value returned on overflow.
	localparam logic [ActWidth-1:0] SatLimit = 8'd127;

	// top of the overflow test; the bit above it is the sign.
	localparam int OverflowMsb = 21;

	// handshake controller.
	typedef enum logic [1:0]
	{
		stateIdle,
		stateBusy,
		stateAck,
		stateRelease
	} nodeState;

endpackage

// File: rtl/nodeControl.sv
`timescale 1ns/100ps

module nodeControl
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic resultValid,
	output logic capture,
	output logic ack
);

	import nodePkg::*;

	nodeState state;
	nodeState stateNext;

	// operands are taken on the edge that leaves idle.
	assign capture = (state == stateIdle) && req;

	always_comb
	begin
		stateNext = state;
		case (state)
			stateIdle:
			begin
				if (req)
					stateNext = stateBusy;
			end
			stateBusy:
			begin
				// wait for the quantizer.
				if (resultValid)
					stateNext = stateAck;
			end
			stateAck:
			begin
				// held here as long as the requester keeps req up.
				if (!req)
					stateNext = stateRelease;
			end
			stateRelease:
			begin
				stateNext = stateIdle;
			end
			default:
			begin
				stateNext = stateIdle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stateIdle;
			ack <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			// registered copy of the ack state.
			ack <= (stateNext == stateAck);
		end
	end

endmodule

// File: rtl/dotProduct.sv
`timescale 1ns/100ps

module dotProduct
#(
	parameter int NumInputs = nodePkg::DefaultInputs,
	parameter int GroupSize = nodePkg::DefaultGroupSize
)
(
	input  logic clk,
	input  logic reset,
	input  logic capture,
	input  logic signed [nodePkg::ActWidth-1:0] features [NumInputs],
	output logic signed [nodePkg::AccWidth-1:0] total,
	output logic totalValid
);

	import nodePkg::*;

	// last group may be short.
	localparam int NumGroups = (NumInputs + GroupSize - 1) / GroupSize;

	logic signed [ActWidth-1:0] operands [NumInputs];
	logic signed [ProdWidth-1:0] products [NumInputs];
	logic signed [AccWidth-1:0] groupSums [NumGroups];
	logic signed [AccWidth-1:0] partialSums [NumGroups];
	logic signed [AccWidth-1:0] totalNext;
	logic operandValid;
	logic partialValid;

	// operand capture, once per transaction.
	always_ff @(posedge clk)
	begin
		if (capture)
			operands <= features;
	end

	genvar i;
	genvar g;

	// signed 8x8 products, sign-extended first.
	generate
		for (i = 0; i < NumInputs; i++)
		begin : genProduct
			assign products[i] = ProdWidth'(operands[i]) * ProdWidth'(NodeWeights[i]);
		end
	endgenerate

	// one adder tree per group.
	generate
		for (g = 0; g < NumGroups; g++)
		begin : genGroup
			localparam int First = g * GroupSize;
			localparam int Count =
				(NumInputs - First < GroupSize) ? NumInputs - First : GroupSize;

			logic signed [AccWidth-1:0] sum;

			always_comb
			begin
				sum = '0;
				for (int k = 0; k < Count; k++)
					sum = sum + AccWidth'(products[First + k]);
			end

			assign groupSums[g] = sum;
		end
	endgenerate

	// stage one.
	always_ff @(posedge clk)
	begin
		if (operandValid)
			partialSums <= groupSums;
	end

	// group total plus bias.
	always_comb
	begin
		totalNext = NodeBias;
		for (int n = 0; n < NumGroups; n++)
			totalNext = totalNext + partialSums[n];
	end

	// stage two.
	always_ff @(posedge clk)
	begin
		if (partialValid)
			total <= totalNext;
	end

	// valid bit walks alongside the data.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			operandValid <= 1'b0;
			partialValid <= 1'b0;
			totalValid <= 1'b0;
		end
		else
		begin
			operandValid <= capture;
			partialValid <= operandValid;
			totalValid <= partialValid;
		end
	end

endmodule

// File: rtl/activationQuantize.sv
`timescale 1ns/100ps

module activationQuantize
(
	input  logic clk,
	input  logic reset,
	input  logic signed [nodePkg::AccWidth-1:0] total,
	input  logic totalValid,
	output logic [nodePkg::ActWidth-1:0] result,
	output logic resultValid
);

	import nodePkg::*;

	// lowest bit that counts as overflow; also the top bit of the kept field.
	localparam int KeepMsb = FracBits + ActWidth - 1;

	logic [ActWidth-1:0] quantized;

	// relu, then saturate or round half up.
	always_comb
	begin
		if (total[AccWidth-1])
			quantized = '0;
		else if (|total[OverflowMsb:KeepMsb])
			quantized = SatLimit;
		else
			// can reach 128 at the top of the range.
			quantized = total[KeepMsb:FracBits] + ActWidth'(total[FracBits-1]);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= totalValid;
			// held until the next total arrives.
			if (totalValid)
				result <= quantized;
		end
	end

endmodule

// File: rtl/nodeTop.sv
`timescale 1ns/100ps

module nodeTop
#(
	parameter int NumInputs = nodePkg::DefaultInputs,
	parameter int GroupSize = nodePkg::DefaultGroupSize
)
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic signed [nodePkg::ActWidth-1:0] features [NumInputs],
	output logic ack,
	output logic [nodePkg::ActWidth-1:0] result
);

	import nodePkg::*;

	logic capture;
	logic signed [AccWidth-1:0] total;
	logic totalValid;
	logic resultValid;

	// req/ack sequencing.
	nodeControl control_i
	(
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.resultValid (resultValid),
		.capture     (capture),
		.ack         (ack)
	);

	// two-stage weighted sum.
	dotProduct
	#(
		.NumInputs (NumInputs),
		.GroupSize (GroupSize)
	)
	dotProduct_i
	(
		.clk        (clk),
		.reset      (reset),
		.capture    (capture),
		.features   (features),
		.total      (total),
		.totalValid (totalValid)
	);

	// 8-bit output stage.
	activationQuantize quantize_i
	(
		.clk         (clk),
		.reset       (reset),
		.total       (total),
		.totalValid  (totalValid),
		.result      (result),
		.resultValid (resultValid)
	);

endmodule

// File: testbench/nodeChecker.sv
`timescale 1ns/100ps

module nodeChecker
#(
	parameter int NumInputs = nodePkg::DefaultInputs
)
(
	input logic clk,
	input logic reset,
	input logic req,
	input logic signed [nodePkg::ActWidth-1:0] features [NumInputs],
	input logic ack,
	input logic [nodePkg::ActWidth-1:0] result
);

	import nodePkg::*;

	// edges from the first req sample to the ack register.
	localparam int AckLatency = 4;

	logic signed [ActWidth-1:0] captured [NumInputs];
	logic [ActWidth-1:0] expected;
	logic inFlight;
	logic anyReq;
	logic reqPrev;
	logic ackPrev;
	int edgeCount;
	int startEdge;
	int errorCount;
	int checkCount;

	// weighted sum plus bias, then relu, saturation and round half up.
	function automatic logic [ActWidth-1:0] referenceResult(
		input logic signed [ActWidth-1:0] f [NumInputs]
	);
		longint acc;
		acc = longint'(NodeBias);
		for (int i = 0; i < NumInputs; i++)
			acc = acc + longint'(f[i]) * longint'(NodeWeights[i]);
		if (acc < 0)
			return '0;
		// any bit from 13 up means the sum is at least 8192.
		if (acc >= (longint'(1) << (FracBits + ActWidth - 1)))
			return SatLimit;
		return ActWidth'((acc + (longint'(1) << (FracBits - 1))) >>> FracBits);
	endfunction

	initial
	begin
		inFlight = 1'b0;
		anyReq = 1'b0;
		reqPrev = 1'b0;
		ackPrev = 1'b0;
		edgeCount = 0;
		startEdge = 0;
		errorCount = 0;
		checkCount = 0;
	end

	always @(posedge clk)
	begin
		edgeCount = edgeCount + 1;
		if (reset)
		begin
			inFlight = 1'b0;
			anyReq = 1'b0;
		end
		else
		begin
			// nothing may move before the first request.
			if (!anyReq && ack)
			begin
				$display("error: ack = %h before any req, expected 0", ack);
				errorCount++;
			end
			if (!anyReq && result != '0)
			begin
				$display("error: result = %h before any req, expected 00", result);
				errorCount++;
			end
			if (!inFlight && req && !ack)
			begin
				inFlight = 1'b1;
				anyReq = 1'b1;
				startEdge = edgeCount;
				captured = features;
			end
			if (ack && !ackPrev)
			begin
				if (!inFlight)
				begin
					$display("ack rose with no request outstanding");
					errorCount++;
				end
				else
				begin
					// ack was registered one edge before this sample.
					if (edgeCount - 1 - startEdge != AckLatency)
					begin
						$display("ack rose %0d edges after req was sampled, expected %0d",
							edgeCount - 1 - startEdge, AckLatency);
						errorCount++;
					end
					expected = referenceResult(captured);
					if (result != expected)
					begin
						$display("error: result = %h, expected %h", result, expected);
						errorCount++;
					end
					checkCount++;
				end
			end
			if (!ack && ackPrev)
			begin
				if (reqPrev)
				begin
					$display("ack dropped while req was still held high");
					errorCount++;
				end
				inFlight = 1'b0;
			end
		end
		ackPrev = ack;
		reqPrev = req;
	end

endmodule

// File: testbench/nodeTb.sv
`timescale 1ns/100ps

module nodeTb;

	import nodePkg::*;

	localparam int NumInputs = DefaultInputs;
	localparam int GroupSize = DefaultGroupSize;
	localparam int NumDirected = 8;
	localparam int NumRandom = 200;
	localparam int NumTransactions = NumDirected + NumRandom;
	// a transaction takes at most 11 cycles here.
	localparam int TimeoutCycles = NumTransactions * 12 + 100;

	logic clk;
	logic reset;
	logic req;
	logic signed [ActWidth-1:0] features [NumInputs];
	logic signed [ActWidth-1:0] stimulus [NumInputs];
	logic ack;
	logic [ActWidth-1:0] result;
	int cycleCount;
	int driverErrors;

	nodeTop
	#(
		.NumInputs (NumInputs),
		.GroupSize (GroupSize)
	)
	dut_i
	(
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.features (features),
		.ack      (ack),
		.result   (result)
	);

	nodeChecker
	#(
		.NumInputs (NumInputs)
	)
	checker_i
	(
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.features (features),
		.ack      (ack),
		.result   (result)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("timeout: the test did not finish within %0d cycles", TimeoutCycles);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic clearStimulus();
		for (int i = 0; i < NumInputs; i++)
			stimulus[i] = '0;
	endtask

	// one value where the weight is positive, another where it is negative.
	task automatic fillBySign(
		input logic signed [ActWidth-1:0] posValue,
		input logic signed [ActWidth-1:0] negValue
	);
		for (int i = 0; i < NumInputs; i++)
		begin
			if (NodeWeights[i] > 0)
				stimulus[i] = posValue;
			else if (NodeWeights[i] < 0)
				stimulus[i] = negValue;
			else
				stimulus[i] = '0;
		end
	endtask

	task automatic randomStimulus();
		for (int i = 0; i < NumInputs; i++)
			stimulus[i] = ActWidth'($urandom % 256);
	endtask

	// full four-phase handshake, req held for some extra cycles.
	task automatic runTransaction();
		int holdCycles;
		holdCycles = int'($urandom % 4);
		@(negedge clk);
		features = stimulus;
		req = 1'b1;
		while (!ack)
			@(negedge clk);
		repeat (holdCycles)
			@(negedge clk);
		req = 1'b0;
		@(negedge clk);
		if (ack)
		begin
			$display("ack still high one edge after req was dropped");
			driverErrors++;
		end
		while (ack)
			@(negedge clk);
		// controller passes through release back to idle.
		@(negedge clk);
	endtask

	initial
	begin
		void'($urandom(42));
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		cycleCount = 0;
		driverErrors = 0;
		clearStimulus();
		features = stimulus;
		repeat (5)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (3)
			@(negedge clk);

		clearStimulus();
		runTransaction();
		fillBySign(8'sd127, -8'sd128);
		runTransaction();
		fillBySign(-8'sd128, 8'sd127);
		runTransaction();

		// weight 2 at input 3, total 542 so bit 5 is clear.
		clearStimulus();
		stimulus[3] = 8'sd15;
		runTransaction();
		// total 544, bit 5 set.
		stimulus[3] = 8'sd16;
		runTransaction();
		// total 8176 rounds up past the saturation value.
		stimulus[15] = 8'sd127;
		stimulus[16] = 8'sd36;
		stimulus[3] = 8'sd9;
		runTransaction();
		// total 8192, first saturating sum.
		stimulus[3] = 8'sd17;
		runTransaction();
		// total 8158.
		stimulus[3] = 8'sd0;
		runTransaction();

		for (int n = 0; n < NumRandom; n++)
		begin
			randomStimulus();
			runTransaction();
		end

		repeat (2)
			@(negedge clk);
		if (checker_i.checkCount != NumTransactions)
		begin
			$display("only %0d of %0d results were checked", checker_i.checkCount,
				NumTransactions);
			driverErrors++;
		end
		$display("checker errors: %0d, driver errors: %0d", checker_i.errorCount, driverErrors);
		if (checker_i.errorCount == 0 && driverErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: all.f
rtl/nodePkg.sv
rtl/nodeControl.sv
rtl/dotProduct.sv
rtl/activationQuantize.sv
rtl/nodeTop.sv
testbench/nodeChecker.sv
testbench/nodeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= nodeTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors
FAIL_MSG ?= Finished with errors
VFLAGS ?= --binary --timing --timescale 1ns/100ps

SOURCES := $(wildcard rtl/*.sv testbench/*.sv)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BINARY)
	-$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not complete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
